/* Bender.yml */
package:
  name: ahb_in_stage

sources:
  # RTL in compile order
  - files:
      - source/ahb_in_stage_pkg.sv
      - source/ahb_pend_ctrl.sv
      - source/ahb_hold_reg.sv
      - source/ahb_burst_fix.sv
      - source/ahb_in_stage.sv

  # Testbench and its vector table
  - target: test
    include_dirs:
      - verification
    files:
      - verification/tb_ahb_in_stage.sv

/* build.f */
+incdir+verification
source/ahb_in_stage_pkg.sv
source/ahb_pend_ctrl.sv
source/ahb_hold_reg.sv
source/ahb_burst_fix.sv
source/ahb_in_stage.sv
verification/tb_ahb_in_stage.sv

/* source/ahb_burst_fix.sv */
module ahb_burst_fix
  import ahb_in_stage_pkg::*;
(
  input  logic    HCLK,
  input  logic    HRESETn,
  input  htrans_t HTRANSS,         // Live transfer type
  input  addr_t   HADDRS,          // Live address for boundary check
  input  hsize_t  HSIZES,
  input  hburst_t HBURSTS,
  input  logic    HREADYS,
  input  logic    load_reg,        // Address phase accepted
  input  logic    active_ip,       // Output stage granted
  input  htrans_t trans_int,       // Type from hold mux
  input  hburst_t burst_int,       // Burst from hold mux
  input  htrans_t transb,          // Raw type of presented beat
  output htrans_t trans_ip,        // Rewritten type to output stage
  output hburst_t burst_ip         // Rewritten burst to output stage
);

  logic      burst_override;        // Remaining beats go out as INCR
  logic      burst_override_next;
  logic      bound;                 // Last beat sat at wrap edge
  logic      bound_next;
  logic      bound_en;
  wrap_idx_t offset_addr;           // Beat index from address
  wrap_idx_t check_addr;            // Index padded to window

  // ----------------------------------------------------------------------
  // Early burst termination
  // ----------------------------------------------------------------------

  // A SEQ that had to wait for the grant means the burst was broken
  // and finishes as an undefined-length burst
  always_comb
  begin
    burst_override_next = burst_override;
    if (HTRANSS == TRN_NONSEQ || HTRANSS == TRN_IDLE)
      burst_override_next = 1'b0;   // New burst or none
    else if (HTRANSS == TRN_SEQ && load_reg && !active_ip)
      burst_override_next = 1'b1;
  end

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      burst_override <= 1'b0;
    else if (HREADYS)
      burst_override <= burst_override_next;
  end

  // ----------------------------------------------------------------------
  // Wrap boundary detection
  // ----------------------------------------------------------------------

  // Beat index scaled by transfer size
  always_comb
  begin
    case (HSIZES)
      3'b000:  offset_addr = HADDRS[3:0];   // Byte
      3'b001:  offset_addr = HADDRS[4:1];   // Halfword
      3'b010:  offset_addr = HADDRS[5:2];   // Word
      3'b011:  offset_addr = HADDRS[6:3];   // Doubleword
      default: offset_addr = HADDRS[3:0];   // 128 bits and wider
    endcase
  end

  // Bits above the wrap length are forced high
  always_comb
  begin
    case (HBURSTS)
      BUR_WRAP4:
      begin
        check_addr[3:2] = FILL_WRAP4;
        check_addr[1:0] = offset_addr[1:0];
      end
      BUR_WRAP8:
      begin
        check_addr[3]   = FILL_WRAP8;
        check_addr[2:0] = offset_addr[2:0];
      end
      BUR_WRAP16:
        check_addr = offset_addr;
      default:
        check_addr = '0;            // Incrementing bursts never wrap
    endcase
  end

  assign bound_next = (check_addr == WRAP_LAST);

  assign bound_en = HTRANSS[1] & HREADYS;  // Every NONSEQ or SEQ taken

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      bound <= 1'b0;
    else if (bound_en)
      bound <= bound_next;
  end

  // ----------------------------------------------------------------------
  // Output rewrite
  // ----------------------------------------------------------------------

  // Past the wrap edge SEQ restarts as NONSEQ and BUSY drops to IDLE
  assign trans_ip = (burst_override && bound) ? {trans_int[1], 1'b0} : trans_int;

  // First beat keeps its own burst type
  assign burst_ip = (burst_override && transb != TRN_NONSEQ) ? BUR_INCR : burst_int;

  // A SEQ sent out after a break never keeps its fixed-length burst type
  property p_broken_seq_is_incr;
    @(posedge HCLK) disable iff (!HRESETn)
      (burst_override && trans_ip == TRN_SEQ) |-> (burst_ip == BUR_INCR);
  endproperty

  a_broken_seq_is_incr: assert property (p_broken_seq_is_incr)
    else $error("SEQ of a broken burst not shown as INCR");

endmodule

/* source/ahb_hold_reg.sv */
module ahb_hold_reg
  import ahb_in_stage_pkg::*;
(
  input  logic    HCLK,
  input  logic    HRESETn,
  input  logic    load_reg,        // Capture strobe
  input  logic    pend_tran_reg,   // Select held copy
  input  logic    HSELS,
  input  addr_t   HADDRS,
  input  htrans_t HTRANSS,
  input  logic    HWRITES,
  input  hsize_t  HSIZES,
  input  hburst_t HBURSTS,
  input  hprot_t  HPROTS,
  input  logic    HMASTLOCKS,
  output logic    sel_ip,          // To output stage
  output addr_t   addr_ip,
  output logic    write_ip,
  output hsize_t  size_ip,
  output hprot_t  prot_ip,
  output logic    mastlock_ip,
  output htrans_t trans_int,       // Before boundary rewrite
  output hburst_t burst_int,       // Before override
  output htrans_t transb           // Raw type for burst decision
);

  // ----------------------------------------------------------------------
  // Holding register bank
  // ----------------------------------------------------------------------

  htrans_t reg_trans;      // Captured HTRANSS
  addr_t   reg_addr;
  logic    reg_write;
  hsize_t  reg_size;
  hburst_t reg_burst;
  hprot_t  reg_prot;
  logic    reg_mastlock;

  // Transfer type steers the burst override so it starts from IDLE
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      reg_trans <= TRN_IDLE;
    else if (load_reg)
      reg_trans <= HTRANSS;
  end

  // Address and control payload
  always_ff @(posedge HCLK)
  begin
    if (load_reg)
    begin
      reg_addr     <= HADDRS;
      reg_write    <= HWRITES;
      reg_size     <= HSIZES;
      reg_burst    <= HBURSTS;
      reg_prot     <= HPROTS;
      reg_mastlock <= HMASTLOCKS;
    end
  end

  // ----------------------------------------------------------------------
  // Live bus or held transfer
  // ----------------------------------------------------------------------

  always_comb
  begin
    if (!pend_tran_reg)
    begin
      // Straight through in the same cycle
      sel_ip      = HSELS;
      trans_int   = HTRANSS;
      addr_ip     = HADDRS;
      write_ip    = HWRITES;
      size_ip     = HSIZES;
      burst_int   = HBURSTS;
      prot_ip     = HPROTS;
      mastlock_ip = HMASTLOCKS;
    end
    else
    begin
      sel_ip      = 1'b1;         // Held beat always targets this path
      trans_int   = TRN_NONSEQ;   // Restarts on the new path
      addr_ip     = reg_addr;
      write_ip    = reg_write;
      size_ip     = reg_size;
      burst_int   = reg_burst;
      prot_ip     = reg_prot;
      mastlock_ip = reg_mastlock;
    end
  end

  // Original type of the presented beat
  always_comb
  begin
    if (pend_tran_reg)
      transb = reg_trans;
    else
      transb = HTRANSS;
  end

endmodule

/* source/ahb_in_stage.sv */
module ahb_in_stage
  import ahb_in_stage_pkg::*;
(
  input  logic    HCLK,
  input  logic    HRESETn,
  // Requester address phase
  input  logic    HSELS,
  input  addr_t   HADDRS,
  input  htrans_t HTRANSS,
  input  logic    HWRITES,
  input  hsize_t  HSIZES,
  input  hburst_t HBURSTS,
  input  hprot_t  HPROTS,
  input  logic    HMASTLOCKS,
  input  logic    HREADYS,
  // From output stage
  input  logic    active_ip,
  input  logic    readyout_ip,
  input  hresp_t  resp_ip,
  // Back to requester
  output logic    HREADYOUTS,
  output hresp_t  HRESPS,
  // To output stage
  output logic    sel_ip,
  output addr_t   addr_ip,
  output htrans_t trans_ip,
  output logic    write_ip,
  output hsize_t  size_ip,
  output hburst_t burst_ip,
  output hprot_t  prot_ip,
  output logic    mastlock_ip,
  output logic    held_tran_ip
);

  logic    load_reg;       // Address phase accepted
  logic    pend_tran_reg;  // Held transfer present
  htrans_t trans_int;
  hburst_t burst_int;
  htrans_t transb;

  // ----------------------------------------------------------------------
  // Acceptance and response
  // ----------------------------------------------------------------------

  ahb_pend_ctrl ahb_pend_ctrl_inst (
    .HCLK          (HCLK),
    .HRESETn       (HRESETn),
    .HSELS         (HSELS),
    .HTRANSS       (HTRANSS),
    .HREADYS       (HREADYS),
    .active_ip     (active_ip),
    .readyout_ip   (readyout_ip),
    .resp_ip       (resp_ip),
    .load_reg      (load_reg),
    .pend_tran_reg (pend_tran_reg),
    .held_tran_ip  (held_tran_ip),
    .HREADYOUTS    (HREADYOUTS),
    .HRESPS        (HRESPS)
  );

  // ----------------------------------------------------------------------
  // Holding register and output mux
  // ----------------------------------------------------------------------

  ahb_hold_reg ahb_hold_reg_inst (
    .HCLK          (HCLK),
    .HRESETn       (HRESETn),
    .load_reg      (load_reg),
    .pend_tran_reg (pend_tran_reg),
    .HSELS         (HSELS),
    .HADDRS        (HADDRS),
    .HTRANSS       (HTRANSS),
    .HWRITES       (HWRITES),
    .HSIZES        (HSIZES),
    .HBURSTS       (HBURSTS),
    .HPROTS        (HPROTS),
    .HMASTLOCKS    (HMASTLOCKS),
    .sel_ip        (sel_ip),
    .addr_ip       (addr_ip),
    .write_ip      (write_ip),
    .size_ip       (size_ip),
    .prot_ip       (prot_ip),
    .mastlock_ip   (mastlock_ip),
    .trans_int     (trans_int),
    .burst_int     (burst_int),
    .transb        (transb)
  );

  // ----------------------------------------------------------------------
  // Burst rewrite
  // ----------------------------------------------------------------------

  ahb_burst_fix ahb_burst_fix_inst (
    .HCLK          (HCLK),
    .HRESETn       (HRESETn),
    .HTRANSS       (HTRANSS),
    .HADDRS        (HADDRS),
    .HSIZES        (HSIZES),
    .HBURSTS       (HBURSTS),
    .HREADYS       (HREADYS),
    .load_reg      (load_reg),
    .active_ip     (active_ip),
    .trans_int     (trans_int),
    .burst_int     (burst_int),
    .transb        (transb),
    .trans_ip      (trans_ip),
    .burst_ip      (burst_ip)
  );

  // Held beat must not be overwritten while the requester is stalled
  property p_no_load_over_held;
    @(posedge HCLK) disable iff (!HRESETn)
      (pend_tran_reg && !HREADYOUTS) |-> !load_reg;
  endproperty

  a_no_load_over_held: assert property (p_no_load_over_held)
    else $error("Holding register reloaded while a transfer is held");

endmodule

/* source/ahb_in_stage_pkg.sv */
package ahb_in_stage_pkg;

  // ----------------------------------------------------------------------
  // AHB field widths
  // ----------------------------------------------------------------------

  typedef logic [31:0] addr_t;     // HADDR
  typedef logic [1:0]  htrans_t;   // HTRANS
  typedef logic [2:0]  hsize_t;    // HSIZE
  typedef logic [2:0]  hburst_t;   // HBURST
  typedef logic [3:0]  hprot_t;    // HPROT
  typedef logic [1:0]  hresp_t;    // HRESP

  // Beat position inside a wrap window, up to 16 beats
  typedef logic [3:0]  wrap_idx_t;

  // ----------------------------------------------------------------------
  // HTRANS encodings
  // ----------------------------------------------------------------------

  localparam htrans_t TRN_IDLE   = 2'b00;  // No transfer
  localparam htrans_t TRN_BUSY   = 2'b01;  // Master inserting a wait inside a burst
  localparam htrans_t TRN_NONSEQ = 2'b10;  // First beat or single
  localparam htrans_t TRN_SEQ    = 2'b11;  // Remaining beats of a burst

  // ----------------------------------------------------------------------
  // HBURST encodings
  // ----------------------------------------------------------------------

  localparam hburst_t BUR_SINGLE = 3'b000;  // Single transfer
  localparam hburst_t BUR_INCR   = 3'b001;  // Undefined length incrementing
  localparam hburst_t BUR_WRAP4  = 3'b010;
  localparam hburst_t BUR_INCR4  = 3'b011;
  localparam hburst_t BUR_WRAP8  = 3'b100;
  localparam hburst_t BUR_INCR8  = 3'b101;
  localparam hburst_t BUR_WRAP16 = 3'b110;
  localparam hburst_t BUR_INCR16 = 3'b111;

  // ----------------------------------------------------------------------
  // HRESP encodings
  // ----------------------------------------------------------------------

  localparam hresp_t RSP_OKAY  = 2'b00;  // Transfer done
  localparam hresp_t RSP_ERROR = 2'b01;  // Two-cycle error response

  // All-ones beat index marks the last beat before a wrap
  localparam wrap_idx_t WRAP_LAST = 4'b1111;

  // Upper fill used for short wrap windows
  localparam logic [1:0] FILL_WRAP4 = 2'b11;
  localparam logic       FILL_WRAP8 = 1'b1;

endpackage

/* source/ahb_pend_ctrl.sv */
module ahb_pend_ctrl
  import ahb_in_stage_pkg::*;
(
  input  logic    HCLK,
  input  logic    HRESETn,         // Sync reset, active low
  input  logic    HSELS,           // Port selected
  input  htrans_t HTRANSS,         // Transfer type from requester
  input  logic    HREADYS,         // Bus ready seen by requester
  input  logic    active_ip,       // Output stage granted to this port
  input  logic    readyout_ip,     // Ready from output stage
  input  hresp_t  resp_ip,         // Response from output stage
  output logic    load_reg,        // Capture address phase
  output logic    pend_tran_reg,   // Holding register in use
  output logic    held_tran_ip,    // Request to output stage arbiter
  output logic    HREADYOUTS,      // Ready back to requester
  output hresp_t  HRESPS           // Response back to requester
);

  logic addr_valid;   // NONSEQ or SEQ to this port
  logic pend_tran;    // Next value of pending flag
  logic data_valid;   // Data phase of an accepted transfer

  // ----------------------------------------------------------------------
  // Acceptance terms
  // ----------------------------------------------------------------------

  // IDLE and BUSY both have bit 1 clear
  assign addr_valid = HSELS & HTRANSS[1];

  assign load_reg = addr_valid & HREADYS;  // Address phase taken by this stage

  // Data phase follows the address phase only when the bus moves on
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      data_valid <= 1'b0;
    else if (HREADYS)
      data_valid <= addr_valid;
  end

  // ----------------------------------------------------------------------
  // Pending transfer tracking
  // ----------------------------------------------------------------------

  // Set when loaded without a grant
  // Cleared once the output stage completes the held beat
  always_comb
  begin
    pend_tran = pend_tran_reg;
    if (load_reg && !active_ip)
      pend_tran = 1'b1;
    else if (active_ip && readyout_ip)
      pend_tran = 1'b0;
  end

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      pend_tran_reg <= 1'b0;
    else
      pend_tran_reg <= pend_tran;
  end

  // Request stays up while the beat sits in the register
  assign held_tran_ip = load_reg | pend_tran_reg;

  // ----------------------------------------------------------------------
  // Response to requester
  // ----------------------------------------------------------------------

  always_comb
  begin
    if (!data_valid)
    begin
      HREADYOUTS = 1'b1;        // Idle, busy or not selected
      HRESPS     = RSP_OKAY;
    end
    else if (pend_tran_reg)
    begin
      HREADYOUTS = 1'b0;        // Stall while held
      HRESPS     = RSP_OKAY;
    end
    else
    begin
      // Output stage owns the data phase
      HREADYOUTS = readyout_ip;
      HRESPS     = resp_ip;
    end
  end

  // A held beat keeps its data phase open so the requester stays stalled
  property p_held_in_data_phase;
    @(posedge HCLK) disable iff (!HRESETn)
      pend_tran_reg |-> data_valid;
  endproperty

  a_held_in_data_phase: assert property (p_held_in_data_phase)
    else $error("Transfer held without an open data phase");

endmodule

/* verification/tb_ahb_in_stage_vectors.svh */
// Columns: grp rnd | sel trans burst size | addr prot wr lock | rdy act rdyo resp |
//          exp trans burst sel | exp addr held hreadyout hresp
// rnd=1 replaces addr and prot by xorshift values, exp addr follows the driven addr

task automatic build_table;
  // Group 1 after reset, port not selected
  row(1,0, 0,0,0,2, 32'h0,3,0,0,    1,1,1,0,  0,0,0, 32'h0,0,1,0);
  row(1,0, 0,0,0,2, 32'h0,3,0,0,    1,0,0,1,  0,0,0, 32'h0,0,1,0);  // Junk response ignored
  // Group 2 pass-through with grant
  row(2,1, 1,2,0,2, 32'h0,0,0,0,    1,1,1,0,  2,0,1, 32'h0,1,1,0);
  row(2,1, 1,2,0,2, 32'h0,0,1,0,    1,1,1,0,  2,0,1, 32'h0,1,1,0);
  row(2,1, 1,2,1,2, 32'h0,0,0,1,    1,1,1,0,  2,1,1, 32'h0,1,1,0);
  row(2,1, 1,2,1,2, 32'h0,0,0,0,    0,1,0,0,  2,1,1, 32'h0,0,0,0);  // Not taken, no load
  row(2,1, 0,0,0,2, 32'h0,0,0,0,    1,1,1,0,  0,0,0, 32'h0,0,1,0);
  // Group 3 hold without grant, release on active and ready
  row(3,0, 1,2,0,2, 32'h2000,3,1,0, 1,0,0,0,  2,0,1, 32'h2000,1,1,0);
  row(3,0, 1,2,0,2, 32'h3000,3,0,0, 0,0,0,0,  2,0,1, 32'h2000,1,0,0);
  row(3,0, 1,2,0,2, 32'h3000,3,0,0, 0,1,0,0,  2,0,1, 32'h2000,1,0,0);
  row(3,0, 1,2,0,2, 32'h3000,3,0,0, 0,1,1,0,  2,0,1, 32'h2000,1,0,0);
  row(3,0, 1,2,0,2, 32'h3000,3,0,0, 1,1,1,0,  2,0,1, 32'h3000,1,1,0);
  row(3,0, 0,0,0,2, 32'h0,3,0,0,    1,1,1,0,  0,0,0, 32'h0,0,1,0);
  // Group 4 response pass, wait state, two-cycle error, then IDLE
  row(4,0, 1,2,0,2, 32'h4000,3,0,0, 1,1,1,0,  2,0,1, 32'h4000,1,1,0);
  row(4,0, 1,2,0,2, 32'h4004,3,0,0, 0,1,0,0,  2,0,1, 32'h4004,0,0,0);
  row(4,0, 1,2,0,2, 32'h4004,3,0,0, 0,1,0,1,  2,0,1, 32'h4004,0,0,1);
  row(4,0, 1,0,0,2, 32'h4004,3,0,0, 1,1,1,1,  0,0,1, 32'h4004,0,1,1);
  row(4,0, 1,0,0,2, 32'h4004,3,0,0, 1,1,0,1,  0,0,1, 32'h4004,0,1,0);
  // Group 5 INCR4 broken on its second beat
  row(5,0, 1,2,3,2, 32'h5000,3,0,0, 1,1,1,0,  2,3,1, 32'h5000,1,1,0);
  row(5,0, 1,3,3,2, 32'h5004,3,0,0, 1,0,1,0,  3,3,1, 32'h5004,1,1,0);
  row(5,0, 1,3,3,2, 32'h5008,3,0,0, 0,0,0,0,  2,1,1, 32'h5004,1,0,0);
  row(5,0, 1,3,3,2, 32'h5008,3,0,0, 0,1,1,0,  2,1,1, 32'h5004,1,0,0);
  row(5,0, 1,3,3,2, 32'h5008,3,0,0, 1,1,1,0,  3,1,1, 32'h5008,1,1,0);
  row(5,0, 1,3,3,2, 32'h500C,3,0,0, 1,1,1,0,  3,1,1, 32'h500C,1,1,0);
  row(5,0, 0,0,0,2, 32'h0,3,0,0,    1,1,1,0,  0,1,0, 32'h0,0,1,0);
  // Group 6 WRAP4 word burst broken at offset 0xC
  row(6,0, 1,2,2,2, 32'h6008,3,0,0, 1,1,1,0,  2,2,1, 32'h6008,1,1,0);
  row(6,0, 1,3,2,2, 32'h600C,3,0,0, 1,0,1,0,  3,2,1, 32'h600C,1,1,0);
  row(6,0, 1,3,2,2, 32'h6000,3,0,0, 0,0,0,0,  2,1,1, 32'h600C,1,0,0);
  row(6,0, 1,3,2,2, 32'h6000,3,0,0, 0,1,1,0,  2,1,1, 32'h600C,1,0,0);
  row(6,0, 1,1,2,2, 32'h6000,3,0,0, 1,1,1,0,  0,1,1, 32'h6000,0,1,0);  // BUSY as IDLE
  row(6,0, 1,3,2,2, 32'h6000,3,0,0, 1,1,1,0,  2,1,1, 32'h6000,1,1,0);  // SEQ as NONSEQ
  row(6,0, 1,3,2,2, 32'h6004,3,0,0, 1,1,1,0,  3,1,1, 32'h6004,1,1,0);
  row(6,0, 0,0,0,2, 32'h0,3,0,0,    1,1,1,0,  0,1,0, 32'h0,0,1,0);
  row(6,0, 0,0,0,2, 32'h0,3,0,0,    1,1,1,0,  0,0,0, 32'h0,0,1,0);
endtask

/* verification/tb_ahb_in_stage.sv */
module tb_ahb_in_stage
  import ahb_in_stage_pkg::*;
();

  localparam int PERIOD       = 8;
  localparam int RESET_CYCLES = 8;

  // One table row, inputs then expected outputs
  typedef struct packed {
    logic [3:0] grp;
    logic       rnd;       // Address and protection from xorshift
    logic       sel;
    htrans_t    trans;
    hburst_t    burst;
    hsize_t     size;
    addr_t      addr;
    hprot_t     prot;
    logic       wr;
    logic       lock;
    logic       rdy;
    logic       act;
    logic       rdyo;
    hresp_t     resp;
    htrans_t    e_trans;
    hburst_t    e_burst;
    logic       e_sel;
    addr_t      e_addr;
    logic       e_held;
    logic       e_hrdy;
    hresp_t     e_resp;
  } vec_t;

  logic    HCLK;
  logic    HRESETn;
  logic    HSELS;
  addr_t   HADDRS;
  htrans_t HTRANSS;
  logic    HWRITES;
  hsize_t  HSIZES;
  hburst_t HBURSTS;
  hprot_t  HPROTS;
  logic    HMASTLOCKS;
  logic    HREADYS;
  logic    active_ip;
  logic    readyout_ip;
  hresp_t  resp_ip;
  logic    HREADYOUTS;
  hresp_t  HRESPS;
  logic    sel_ip;
  addr_t   addr_ip;
  htrans_t trans_ip;
  logic    write_ip;
  hsize_t  size_ip;
  hburst_t burst_ip;
  hprot_t  prot_ip;
  logic    mastlock_ip;
  logic    held_tran_ip;

  vec_t        table_q[$];
  int          n_rows;        // Zero until the table is built
  int          err_count;
  int          check_count;
  int          group_errs;
  logic [31:0] rng_state;

  ahb_in_stage ahb_in_stage_inst (
    .HCLK         (HCLK),
    .HRESETn      (HRESETn),
    .HSELS        (HSELS),
    .HADDRS       (HADDRS),
    .HTRANSS      (HTRANSS),
    .HWRITES      (HWRITES),
    .HSIZES       (HSIZES),
    .HBURSTS      (HBURSTS),
    .HPROTS       (HPROTS),
    .HMASTLOCKS   (HMASTLOCKS),
    .HREADYS      (HREADYS),
    .active_ip    (active_ip),
    .readyout_ip  (readyout_ip),
    .resp_ip      (resp_ip),
    .HREADYOUTS   (HREADYOUTS),
    .HRESPS       (HRESPS),
    .sel_ip       (sel_ip),
    .addr_ip      (addr_ip),
    .trans_ip     (trans_ip),
    .write_ip     (write_ip),
    .size_ip      (size_ip),
    .burst_ip     (burst_ip),
    .prot_ip      (prot_ip),
    .mastlock_ip  (mastlock_ip),
    .held_tran_ip (held_tran_ip)
  );

  always #(PERIOD / 2) HCLK = ~HCLK;

  `include "tb_ahb_in_stage_vectors.svh"

  // ----------------------------------------------------------------------
  // Table helpers
  // ----------------------------------------------------------------------

  task automatic row(input int grp, input int rnd, input int sel, input int trans,
                     input int burst, input int size, input logic [31:0] addr,
                     input int prot, input int wr, input int lock, input int rdy,
                     input int act, input int rdyo, input int resp, input int e_trans,
                     input int e_burst, input int e_sel, input logic [31:0] e_addr,
                     input int e_held, input int e_hrdy, input int e_resp);
    vec_t v;
    v.grp     = grp[3:0];
    v.rnd     = rnd[0];
    v.sel     = sel[0];
    v.trans   = trans[1:0];
    v.burst   = burst[2:0];
    v.size    = size[2:0];
    v.addr    = addr;
    v.prot    = prot[3:0];
    v.wr      = wr[0];
    v.lock    = lock[0];
    v.rdy     = rdy[0];
    v.act     = act[0];
    v.rdyo    = rdyo[0];
    v.resp    = resp[1:0];
    v.e_trans = e_trans[1:0];
    v.e_burst = e_burst[2:0];
    v.e_sel   = e_sel[0];
    v.e_addr  = e_addr;
    v.e_held  = e_held[0];
    v.e_hrdy  = e_hrdy[0];
    v.e_resp  = e_resp[1:0];
    table_q.push_back(v);
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic string group_name(input int g);
    case (g)
      1:       return "reset";
      2:       return "pass-through";
      3:       return "hold";
      4:       return "response";
      5:       return "burst override";
      6:       return "wrap boundary";
      default: return "unknown";
    endcase
  endfunction

  // ----------------------------------------------------------------------
  // Drive and check
  // ----------------------------------------------------------------------

  task automatic check_value(input string name, input int idx,
                             input logic [31:0] expected, input logic [31:0] actual);
    check_count++;
    assert (actual === expected)
    else
    begin
      $display("Fail row %0d %s: expected %h, actual %h", idx, name, expected, actual);
      err_count++;
      group_errs++;
    end
  endtask

  task automatic drive_row(input vec_t v);
    HSELS       = v.sel;
    HADDRS      = v.addr;
    HTRANSS     = v.trans;
    HWRITES     = v.wr;
    HSIZES      = v.size;
    HBURSTS     = v.burst;
    HPROTS      = v.prot;
    HMASTLOCKS  = v.lock;
    HREADYS     = v.rdy;
    active_ip   = v.act;
    readyout_ip = v.rdyo;
    resp_ip     = v.resp;
  endtask

  task automatic check_row(input int idx, input vec_t v, input vec_t taken);
    vec_t src;
    // Side fields belong to the beat shown on addr_ip, live or held
    if (v.e_addr === v.addr)
      src = v;
    else
      src = taken;
    check_value("trans_ip",     idx, 32'(v.e_trans), 32'(trans_ip));
    check_value("burst_ip",     idx, 32'(v.e_burst), 32'(burst_ip));
    check_value("sel_ip",       idx, 32'(v.e_sel),   32'(sel_ip));
    check_value("addr_ip",      idx, v.e_addr,       addr_ip);
    check_value("held_tran_ip", idx, 32'(v.e_held),  32'(held_tran_ip));
    check_value("HREADYOUTS",   idx, 32'(v.e_hrdy),  32'(HREADYOUTS));
    check_value("HRESPS",       idx, 32'(v.e_resp),  32'(HRESPS));
    check_value("write_ip",     idx, 32'(src.wr),    32'(write_ip));
    check_value("size_ip",      idx, 32'(src.size),  32'(size_ip));
    check_value("prot_ip",      idx, 32'(src.prot),  32'(prot_ip));
    check_value("mastlock_ip",  idx, 32'(src.lock),  32'(mastlock_ip));
  endtask

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------

  initial
  begin : main_seq
    vec_t v;
    vec_t taken;
    int   group_rows;
    HCLK        = 1'b0;
    HRESETn     = 1'b0;
    HSELS       = 1'b0;
    HADDRS      = '0;
    HTRANSS     = TRN_IDLE;
    HWRITES     = 1'b0;
    HSIZES      = '0;
    HBURSTS     = BUR_SINGLE;
    HPROTS      = '0;
    HMASTLOCKS  = 1'b0;
    HREADYS     = 1'b1;
    active_ip   = 1'b0;
    readyout_ip = 1'b1;
    resp_ip     = RSP_OKAY;
    rng_state   = 32'h39e4;
    err_count   = 0;
    check_count = 0;
    group_errs  = 0;
    group_rows  = 0;
    taken       = '0;
    build_table();
    n_rows = table_q.size();
    repeat (RESET_CYCLES) @(posedge HCLK);
    @(negedge HCLK);
    HRESETn = 1'b1;
    for (int i = 0; i < n_rows; i++)
    begin
      v = table_q[i];
      if (v.rnd)
      begin
        rng_state = xorshift32(rng_state);
        v.addr    = rng_state;
        v.e_addr  = rng_state;   // Pass-through must show the same address
        rng_state = xorshift32(rng_state);
        v.prot    = rng_state[3:0];
      end
      @(negedge HCLK);
      drive_row(v);
      #(PERIOD / 2 - 1);         // Just ahead of the next rising edge
      check_row(i, v, taken);
      if (v.sel && v.trans[1] && v.rdy)
        taken = v;               // Latest address phase accepted by the port
      group_rows++;
      if (i == n_rows - 1 || table_q[i + 1].grp != v.grp)
      begin
        $display("Group %0d %s: %0d rows, %0d errors", v.grp, group_name(v.grp),
                 group_rows, group_errs);
        group_rows = 0;
        group_errs = 0;
      end
    end
    $display("Summary: %0d rows, %0d checks, %0d errors", n_rows, check_count, err_count);
    if (err_count == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

  // Bound scales with the table, twice the nominal run time
  initial
  begin : watchdog
    int limit;
    wait (n_rows > 0);
    limit = (n_rows + RESET_CYCLES) * PERIOD * 2;
    #(limit);
    $display("Timeout: vector table not finished after %0d time units", limit);
    $display("TESTS FAILED");
    $finish;
  end

endmodule
